/* logic/avr_core_cfg.svh */
`ifndef AVR_CORE_CFG_SVH
`define AVR_CORE_CFG_SVH

// Program memory of 2K instruction words
`define AVR_PGM_ADDR_W 11

// Data space reached through the X pointer
`define AVR_DATA_ADDR_W 12

// IN and OUT reach the low 64 I/O locations only
`define AVR_IO_ADDR_W 6

// General purpose registers r0 to r31
`define AVR_REG_COUNT 32

`endif

/* logic/avr_core_pkg.sv */
`include "avr_core_cfg.svh"

package avr_core_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t; // Instruction word or X pointer
	typedef logic [4:0] reg_idx_t;
	typedef logic [`AVR_PGM_ADDR_W-1:0] pgm_addr_t;
	typedef logic [`AVR_DATA_ADDR_W-1:0] data_addr_t;
	typedef logic [`AVR_IO_ADDR_W-1:0] io_addr_t;
	typedef logic [7:0] sreg_t;

	// Anything not listed here runs as NOP
	typedef enum logic [3:0] {
		CLS_ALU,
		CLS_LDI,
		CLS_RJMP,
		CLS_BRANCH,
		CLS_IN,
		CLS_OUT,
		CLS_LD_X,
		CLS_ST_X,
		CLS_NOP
	} inst_class_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_PASS // Result is operand b, flags untouched
	} alu_op_t;

	// SREG bit positions, I and T not implemented
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_V = 3;
	localparam int FLAG_S = 4;
	localparam int FLAG_H = 5;

endpackage

/* logic/avr_core_if.sv */
`timescale 1ns/100ps

// Register file access from the core
interface reg_port_if import avr_core_pkg::*; ();
	reg_idx_t rd_idx;
	reg_idx_t rr_idx;
	logic wr_en;
	reg_idx_t wr_idx;
	byte_t wr_data;
	byte_t rd_data;
	byte_t rr_data;
	word_t x_ptr; // r27:r26

	modport core (output rd_idx, rr_idx, wr_en, wr_idx, wr_data,
		input rd_data, rr_data, x_ptr);
	modport regs (input rd_idx, rr_idx, wr_en, wr_idx, wr_data,
		output rd_data, rr_data, x_ptr);
endinterface

// Decoded fields of the current instruction word
interface decode_if import avr_core_pkg::*; ();
	inst_class_t inst_class;
	alu_op_t alu_op;
	reg_idx_t rd_idx;
	reg_idx_t rr_idx;
	logic use_imm;
	byte_t imm;
	logic write_rd;
	logic [2:0] sreg_bit;
	logic branch_if_set;
	pgm_addr_t branch_offset; // Sign extended
	pgm_addr_t rjmp_offset;
	io_addr_t io_addr;

	modport dec (output inst_class, alu_op, rd_idx, rr_idx, use_imm, imm, write_rd,
		sreg_bit, branch_if_set, branch_offset, rjmp_offset, io_addr);
	modport sink (input inst_class, alu_op, rd_idx, rr_idx, use_imm, imm, write_rd,
		sreg_bit, branch_if_set, branch_offset, rjmp_offset, io_addr);
endinterface

/* logic/avr_reg_file.sv */
`timescale 1ns/100ps

`include "avr_core_cfg.svh"

module avr_reg_file import avr_core_pkg::*;
(
	input logic clk,
	input logic rst,
	reg_port_if.regs regs
);

	byte_t reg_q [`AVR_REG_COUNT];

	// Both read ports are combinational
	assign regs.rd_data = reg_q[regs.rd_idx];
	assign regs.rr_data = reg_q[regs.rr_idx];

	// X pointer, high byte in r27
	assign regs.x_ptr = {reg_q[27], reg_q[26]};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `AVR_REG_COUNT; i++)
				reg_q[i] <= '0;
		end
		else if (regs.wr_en)
		begin
			reg_q[regs.wr_idx] <= regs.wr_data; // Single write port
		end
	end

endmodule

/* logic/avr_decoder.sv */
`timescale 1ns/100ps

module avr_decoder import avr_core_pkg::*;
(
	input word_t inst,
	decode_if.dec dec
);

	always_comb
	begin
		// Field positions shared by most formats
		dec.rd_idx = inst[8:4];
		dec.rr_idx = {inst[9], inst[3:0]};
		dec.imm = {inst[11:8], inst[3:0]};
		dec.sreg_bit = inst[2:0];
		dec.branch_if_set = ~inst[10]; // BRBS has bit 10 clear
		dec.branch_offset = pgm_addr_t'($signed(inst[9:3]));
		dec.rjmp_offset = pgm_addr_t'($signed(inst[11:0]));
		dec.io_addr = {inst[10:9], inst[3:0]};

		dec.inst_class = CLS_NOP;
		dec.alu_op = ALU_PASS;
		dec.use_imm = 1'b0;
		dec.write_rd = 1'b0;

		casez (inst)
			// CPC SBC ADD, CP SUB ADC, AND EOR OR MOV
			16'b0000_01??_????_????,
			16'b0000_1???_????_????,
			16'b0001_01??_????_????,
			16'b0001_1???_????_????,
			16'b0010_????_????_????:
			begin
				dec.inst_class = CLS_ALU;
				// Compares only update flags
				dec.write_rd = (inst[13:10] != 4'b0001) && (inst[13:10] != 4'b0101);
				case (inst[13:10])
					4'b0001, 4'b0010: dec.alu_op = ALU_SBC; // CPC, SBC
					4'b0011: dec.alu_op = ALU_ADD;
					4'b0101, 4'b0110: dec.alu_op = ALU_SUB; // CP, SUB
					4'b0111: dec.alu_op = ALU_ADC;
					4'b1000: dec.alu_op = ALU_AND;
					4'b1001: dec.alu_op = ALU_EOR;
					4'b1010: dec.alu_op = ALU_OR;
					default: dec.alu_op = ALU_PASS; // MOV
				endcase
			end
			// CPI SBCI SUBI ORI ANDI work on r16 to r31
			16'b0011_????_????_????,
			16'b01??_????_????_????:
			begin
				dec.inst_class = CLS_ALU;
				dec.use_imm = 1'b1;
				dec.rd_idx = {1'b1, inst[7:4]};
				dec.write_rd = inst[14]; // Low only for CPI
				case (inst[14:12])
					3'b100: dec.alu_op = ALU_SBC;
					3'b110: dec.alu_op = ALU_OR;
					3'b111: dec.alu_op = ALU_AND;
					default: dec.alu_op = ALU_SUB; // CPI, SUBI
				endcase
			end
			16'b1110_????_????_????:
			begin
				dec.inst_class = CLS_LDI;
				dec.rd_idx = {1'b1, inst[7:4]};
				dec.write_rd = 1'b1;
			end
			16'b1001_000?_????_1100:
			begin
				dec.inst_class = CLS_LD_X;
				dec.write_rd = 1'b1;
			end
			16'b1001_001?_????_1100: dec.inst_class = CLS_ST_X; // Source sits in the Rd field
			16'b1011_0???_????_????:
			begin
				dec.inst_class = CLS_IN;
				dec.write_rd = 1'b1;
			end
			16'b1011_1???_????_????: dec.inst_class = CLS_OUT;
			16'b1100_????_????_????: dec.inst_class = CLS_RJMP;
			16'b1111_0???_????_????: dec.inst_class = CLS_BRANCH; // BRBS and BRBC
			default: dec.inst_class = CLS_NOP;
		endcase
	end

endmodule

/* logic/avr_alu.sv */
`timescale 1ns/100ps

module avr_alu import avr_core_pkg::*;
(
	input alu_op_t op,
	input byte_t a,
	input byte_t b,
	input sreg_t sreg_in,
	output byte_t result,
	output sreg_t sreg_out
);

	logic carry_in;
	logic [8:0] add_full;
	logic [4:0] add_low;
	logic [8:0] sub_full;
	logic [4:0] sub_low;
	logic flag_v;

	assign carry_in = (op == ALU_ADC || op == ALU_SBC) ? sreg_in[FLAG_C] : 1'b0;

	// Bit 8 carries out of the byte, bit 4 out of the low nibble
	assign add_full = {1'b0, a} + {1'b0, b} + {8'd0, carry_in};
	assign add_low = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, carry_in};

	// Same for subtraction, a set top bit means borrow
	assign sub_full = {1'b0, a} - {1'b0, b} - {8'd0, carry_in};
	assign sub_low = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, carry_in};

	always_comb
	begin
		result = b;
		sreg_out = sreg_in;
		flag_v = 1'b0;

		case (op)
			ALU_ADD, ALU_ADC:
			begin
				result = add_full[7:0];
				flag_v = (a[7] == b[7]) && (add_full[7] != a[7]); // Same signs in, other sign out
				sreg_out[FLAG_C] = add_full[8];
				sreg_out[FLAG_H] = add_low[4];
			end
			ALU_SUB, ALU_SBC:
			begin
				result = sub_full[7:0];
				flag_v = (a[7] != b[7]) && (sub_full[7] != a[7]);
				sreg_out[FLAG_C] = sub_full[8];
				sreg_out[FLAG_H] = sub_low[4];
			end
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_EOR: result = a ^ b;
			default: result = b;
		endcase

		// C and H stay as they are for the logic ops
		if (op != ALU_PASS)
		begin
			sreg_out[FLAG_V] = flag_v;
			sreg_out[FLAG_N] = result[7];
			sreg_out[FLAG_S] = result[7] ^ flag_v;
			if (op == ALU_SBC)
				sreg_out[FLAG_Z] = (result == 8'd0) && sreg_in[FLAG_Z]; // Multi byte compare chain
			else
				sreg_out[FLAG_Z] = (result == 8'd0);
		end
	end

endmodule

/* logic/avr_core.sv */
`timescale 1ns/100ps

module avr_core import avr_core_pkg::*;
(
	input logic clk,
	input logic rst,
	output pgm_addr_t pgm_addr,
	input word_t pgm_data,
	output data_addr_t data_addr,
	input byte_t data_in,
	output byte_t data_out,
	output logic data_we,
	output logic data_re,
	output io_addr_t io_addr,
	input byte_t io_in,
	output byte_t io_out,
	output logic io_we,
	output logic io_re
);

	pgm_addr_t pc;
	pgm_addr_t pc_plus_one;
	pgm_addr_t pc_next;
	sreg_t sreg;
	sreg_t alu_sreg;
	byte_t alu_b;
	byte_t alu_result;
	byte_t wb_data;
	logic branch_taken;

	reg_port_if rp();
	decode_if dec_bus();

	avr_decoder u_decoder (
		.inst(pgm_data),
		.dec(dec_bus.dec)
	);

	avr_reg_file u_reg_file (
		.clk(clk),
		.rst(rst),
		.regs(rp.regs)
	);

	avr_alu u_alu (
		.op(dec_bus.alu_op),
		.a(rp.rd_data),
		.b(alu_b),
		.sreg_in(sreg),
		.result(alu_result),
		.sreg_out(alu_sreg)
	);

	assign pgm_addr = pc; // Program memory answers in the same cycle
	assign pc_plus_one = pc + 1'b1;

	assign rp.rd_idx = dec_bus.rd_idx;
	assign rp.rr_idx = dec_bus.rr_idx;
	assign alu_b = dec_bus.use_imm ? dec_bus.imm : rp.rr_data;

	// Write back source
	always_comb
	begin
		case (dec_bus.inst_class)
			CLS_LDI: wb_data = dec_bus.imm;
			CLS_IN: wb_data = io_in;
			CLS_LD_X: wb_data = data_in;
			default: wb_data = alu_result;
		endcase
	end

	assign rp.wr_en = dec_bus.write_rd;
	assign rp.wr_idx = dec_bus.rd_idx;
	assign rp.wr_data = wb_data;

	// Strobes cover the whole instruction cycle and stay low in reset
	assign data_addr = data_addr_t'(rp.x_ptr);
	assign data_out = rp.rd_data;
	assign data_we = !rst && (dec_bus.inst_class == CLS_ST_X);
	assign data_re = !rst && (dec_bus.inst_class == CLS_LD_X);
	assign io_addr = dec_bus.io_addr;
	assign io_out = rp.rd_data;
	assign io_we = !rst && (dec_bus.inst_class == CLS_OUT);
	assign io_re = !rst && (dec_bus.inst_class == CLS_IN);

	assign branch_taken = (dec_bus.inst_class == CLS_BRANCH) &&
		(sreg[dec_bus.sreg_bit] == dec_bus.branch_if_set);

	always_comb
	begin
		if (dec_bus.inst_class == CLS_RJMP)
			pc_next = pc_plus_one + dec_bus.rjmp_offset;
		else if (branch_taken)
			pc_next = pc_plus_one + dec_bus.branch_offset;
		else
			pc_next = pc_plus_one;
	end

	// PC and SREG move together with the register write
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= '0;
			sreg <= '0;
		end
		else
		begin
			pc <= pc_next;
			sreg <= alu_sreg; // Equals sreg for non-flag ops
		end
	end

endmodule

/* tests/avr_core_assert.sv */
`timescale 1ns/100ps

module avr_core_assert
(
	input logic clk,
	input logic rst,
	input logic data_we,
	input logic data_re,
	input logic io_we,
	input logic io_re
);

	int fail_count = 0; // Read by the testbench at the end

	data_rw_excl: assert property (@(posedge clk) !(data_we && data_re))
	else
	begin
		fail_count++;
		$error("data_we and data_re high in the same cycle");
	end

	io_rw_excl: assert property (@(posedge clk) !(io_we && io_re))
	else
	begin
		fail_count++;
		$error("io_we and io_re high in the same cycle");
	end

	// Buses stay idle while the core is held in reset
	quiet_in_reset: assert property (@(posedge clk)
		rst |-> !(data_we || data_re || io_we || io_re))
	else
	begin
		fail_count++;
		$error("strobe high while rst is asserted");
	end

endmodule

bind avr_core avr_core_assert u_assert (
	.clk(clk),
	.rst(rst),
	.data_we(data_we),
	.data_re(data_re),
	.io_we(io_we),
	.io_re(io_re)
);

/* tests/avr_core_checker.sv */
`timescale 1ns/100ps

module avr_core_checker import avr_core_pkg::*;
(
	input logic clk,
	input logic rst,
	input io_addr_t io_addr,
	input byte_t io_out,
	input logic io_we,
	input logic io_re,
	input data_addr_t data_addr,
	input byte_t data_out,
	input logic data_we,
	input logic data_re,
	output logic all_seen,
	output int error_count,
	output int unexpected_count
);

	// Entry is {kind, 12 bit address, value}, kind 1 for data writes
	logic [20:0] expected [$];
	int exp_total = 0;
	int next_idx = 0;
	int mismatches = 0;
	int unexpected = 0;

	assign all_seen = (exp_total > 0) && (next_idx >= exp_total);
	assign error_count = mismatches;
	assign unexpected_count = unexpected;

	task add_expected(input logic kind, input logic [11:0] addr, input byte_t value);
		expected.push_back({kind, addr, value});
		exp_total++;
	endtask

	always @(posedge clk)
	begin
		logic [20:0] entry;
		logic kind;
		logic [11:0] addr;
		byte_t value;

		kind = data_we;
		addr = data_we ? 12'(data_addr) : 12'(io_addr);
		value = data_we ? data_out : io_out;
		if (rst && (io_we || io_re || data_we || data_re))
		begin
			mismatches++;
			$display("CHECK FAILED at %0t: bus strobe high during reset", $time);
		end
		else if (io_we || data_we)
		begin
			if (next_idx >= exp_total)
			begin
				unexpected++;
				$display("CHECK FAILED at %0t: unexpected %s write %h = %h", $time,
					kind ? "data" : "io", addr, value);
			end
			else
			begin
				entry = expected[next_idx];
				if (entry !== {kind, addr, value})
				begin
					mismatches++;
					$display("CHECK FAILED at %0t: write %0d expected %s %h = %h, got %s %h = %h",
						$time, next_idx, entry[20] ? "data" : "io", entry[19:8], entry[7:0],
						kind ? "data" : "io", addr, value);
				end
				next_idx++;
			end
		end
	end

endmodule

/* tests/avr_core_tb.sv */
`timescale 1ns/100ps

`include "avr_core_cfg.svh"

module avr_core_tb import avr_core_pkg::*;
();

	logic clk;
	logic rst;
	pgm_addr_t pgm_addr;
	word_t pgm_data;
	data_addr_t data_addr;
	byte_t data_in;
	byte_t data_out;
	logic data_we;
	logic data_re;
	io_addr_t io_addr;
	byte_t io_in;
	byte_t io_out;
	logic io_we;
	logic io_re;
	logic all_seen;
	int error_count;
	int unexpected_count;

	logic [31:0] records [256]; // type, address, value
	word_t rom [2**`AVR_PGM_ADDR_W];
	byte_t io_regs [2**`AVR_IO_ADDR_W];
	byte_t ram [2**`AVR_DATA_ADDR_W];

	// Memories answer within the cycle, read data only under the read strobe
	assign pgm_data = rom[pgm_addr];
	assign io_in = io_re ? io_regs[io_addr] : 8'h00;
	assign data_in = data_re ? ram[data_addr] : 8'h00;

	always @(posedge clk)
	begin
		if (data_we)
			ram[data_addr] <= data_out;
	end

	avr_core uut (.*);

	avr_core_checker chk (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		int cycles;
		int timeouts;
		int total;

		rst = 1'b1;
		timeouts = 0;
		for (int i = 0; i < 256; i++)
			records[i] = '0;
		for (int i = 0; i < 2**`AVR_PGM_ADDR_W; i++)
			rom[i] = 16'h0000; // NOP
		for (int i = 0; i < 2**`AVR_IO_ADDR_W; i++)
			io_regs[i] = 8'h00;
		for (int i = 0; i < 2**`AVR_DATA_ADDR_W; i++)
			ram[i] = byte_t'(i) ^ byte_t'(i >> 4);
		$readmemh("tests/avr_core_cases.txt", records);
		for (int i = 0; i < 256; i++)
		begin
			case (records[i][31:28])
				4'h1: rom[records[i][26:16]] = records[i][15:0];
				4'h2: io_regs[records[i][21:16]] = records[i][7:0];
				4'h3: ram[records[i][27:16]] = records[i][7:0];
				4'h4: chk.add_expected(1'b0, records[i][27:16], records[i][7:0]);
				4'h5: chk.add_expected(1'b1, records[i][27:16], records[i][7:0]);
				default: ;
			endcase
		end

		repeat (8) @(posedge clk);
		rst <= 1'b0;

		cycles = 0;
		while (!all_seen && cycles < 2000)
		begin
			@(posedge clk);
			cycles++;
		end
		if (!all_seen)
		begin
			$display("Timeout: not all expected writes were seen within 2000 cycles");
			timeouts = 1;
		end
		repeat (16) @(posedge clk); // Catch stray writes from the idle loop

		total = error_count + unexpected_count + timeouts + uut.u_assert.fail_count;
		$display("Errors: %0d mismatches, %0d unexpected writes, %0d timeouts, %0d assertions",
			error_count, unexpected_count, timeouts, uut.u_assert.fail_count);
		if (total == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+logic
logic/avr_core_pkg.sv
logic/avr_core_if.sv
logic/avr_reg_file.sv
logic/avr_decoder.sv
logic/avr_alu.sv
logic/avr_core.sv
tests/avr_core_assert.sv
tests/avr_core_checker.sv
tests/avr_core_tb.sv

/* Bender.yml */
package:
  name: avr_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/avr_core_pkg.sv
      - logic/avr_core_if.sv
      - logic/avr_reg_file.sv
      - logic/avr_decoder.sv
      - logic/avr_alu.sv
      - logic/avr_core.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/avr_core_assert.sv
      - tests/avr_core_checker.sv
      - tests/avr_core_tb.sv

/* tests/avr_core_cases.txt */
// Record is type_address_value in hex, several records per line
// Types: 1 program word, 2 io_in value, 3 initial RAM byte, 4 expected io write, 5 expected data write
1_000_b801 1_001_e30c 1_002_b905 // OUT $01 r0; LDI r16 $3C; OUT $05 r16
1_003_e91c 1_004_e82a 1_005_0f12 1_006_b916 // LDI r17 $9C; LDI r18 $8A; ADD r17 r18; OUT $06
1_007_1f00 1_008_b907 // ADC r16 r16 with carry set; OUT $07 r16
1_009_1b12 1_00a_0b02 1_00b_b918 1_00c_b909 // SUB r17 r18; SBC r16 r18; OUT $08; OUT $09
1_00d_2312 1_00e_2702 1_00f_2b10 // AND r17 r18; EOR r16 r18; OR r17 r16
1_010_2e11 1_011_b81a 1_012_b90b // MOV r1 r17; OUT $0A r1; OUT $0B r16
1_013_1700 1_014_f009 1_015_b91c 1_016_b90c // CP r16 r16; BRBS Z +1 taken; OUT $0C skipped
1_017_3f10 1_018_f408 1_019_b91d 1_01a_b90d // CPI r17 $F0; BRBC C +1 not taken; two OUTs
1_01b_5604 1_01c_f409 1_01d_b90e // SUBI r16 $64 gives zero; BRBC Z +1 not taken; OUT $0E
1_01e_f408 1_01f_b91e 1_020_b91f // BRBC C +1 taken over OUT $0E r17; OUT $0F r17
1_021_b332 1_022_bb30 // IN r19 $12; OUT $10 r19
1_023_e2a3 1_024_e0b1 1_025_933c // X = $123; ST X r19
1_026_e4a0 1_027_e0b2 1_028_914c 1_029_bb41 // X = $240; LD r20 X; OUT $11 r20
1_02a_e2a3 1_02b_e0b1 1_02c_915c 1_02d_bb53 // X = $123; LD r21 X; OUT $13 r21
1_02e_c001 1_02f_bb04 1_030_bb35 1_031_cfff // RJMP over OUT $14; OUT $15 r19; idle loop
2_012_00a5 // io_in at $12
3_240_005a // RAM byte at $240
4_001_0000 4_005_003c 4_006_0026 4_007_0079 // Expected writes in order
4_008_009c 4_009_00ee 4_00a_00ec 4_00b_0064
4_00c_0064 4_00d_00ec 4_00d_0064 4_00e_0000
4_00f_00ec 4_010_00a5 5_123_00a5 4_011_005a
4_013_00a5 4_015_00a5
